//--- hw/sound_pkg.sv
// sound_pkg: sample, volume and register-index types, mixer register indices, volume scaling
package sound_pkg;

	typedef logic signed [15:0] sample_t; // signed pcm sample
	typedef logic [4:0] vol_t;            // 31 = full level, 0 = mute
	typedef logic [7:0] reg_index_t;

	// packed and individual mixer registers
	parameter reg_index_t REG_RESET    = 8'h00;
	parameter reg_index_t REG_VOICE    = 8'h04;
	parameter reg_index_t REG_MASTER   = 8'h22;
	parameter reg_index_t REG_SYNTH    = 8'h26;
	parameter reg_index_t REG_MASTER_L = 8'h30;
	parameter reg_index_t REG_MASTER_R = 8'h31;
	parameter reg_index_t REG_VOICE_L  = 8'h32;
	parameter reg_index_t REG_VOICE_R  = 8'h33;
	parameter reg_index_t REG_SYNTH_L  = 8'h34;
	parameter reg_index_t REG_SYNTH_R  = 8'h35;
	parameter reg_index_t REG_IRQ_SEL  = 8'h80;

	parameter vol_t VOL_FULL = 5'd31;

	// 6 dB per step of the upper four volume bits
	function automatic sample_t volume(sample_t smp, vol_t vol);
		sample_t res;
		if (vol == '0)
			res = '0; // mute
		else
			res = smp >>> (4'd15 - vol[4:1]);
		return res;
	endfunction

endpackage

//--- hw/mixer_regs.sv
// mixer_regs: host index/data port, volume and mode registers, readback, irq routing
module mixer_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           address,
	input  logic                 read,
	input  logic                 write,
	input  logic [7:0]           writedata,
	input  logic                 irq,
	output logic [7:0]           readdata,
	output logic                 irq_5,
	output logic                 irq_7,
	output logic                 irq_10,
	output sound_pkg::vol_t      vol_master_l,
	output sound_pkg::vol_t      vol_master_r,
	output sound_pkg::vol_t      vol_voice_l,
	output sound_pkg::vol_t      vol_voice_r,
	output sound_pkg::vol_t      vol_synth_l,
	output sound_pkg::vol_t      vol_synth_r
);

	sound_pkg::reg_index_t index_reg;
	logic                  enhanced; // sbpro style packing
	logic                  irq_7_en;
	logic                  irq_10_en;
	logic                  irq_5_en;
	logic                  index_wr;
	logic                  data_wr;
	sound_pkg::vol_t       pack_l;
	sound_pkg::vol_t       pack_r;
	logic [7:0]            vol_mask;
	logic [7:0]            reg_val;

	assign index_wr = write && (address == 4'd4);
	assign data_wr  = write && (address == 4'd5);

	// nibble to 5-bit volume, upper nibble is left
	assign pack_l = enhanced ? {writedata[7:5], writedata[7:6]} : {writedata[7:4], writedata[7]};
	assign pack_r = enhanced ? {writedata[3:1], writedata[3:2]} : {writedata[3:0], writedata[3]};

	always_ff @(posedge clk) begin
		if (!rst_n)
			index_reg <= sound_pkg::REG_RESET;
		else if (index_wr)
			index_reg <= writedata;
	end

	// volumes
	always_ff @(posedge clk) begin
		if (!rst_n || (data_wr && index_reg == sound_pkg::REG_RESET)) begin
			vol_master_l <= sound_pkg::VOL_FULL;
			vol_master_r <= sound_pkg::VOL_FULL;
			vol_voice_l  <= sound_pkg::VOL_FULL;
			vol_voice_r  <= sound_pkg::VOL_FULL;
			vol_synth_l  <= sound_pkg::VOL_FULL;
			vol_synth_r  <= sound_pkg::VOL_FULL;
		end else if (data_wr) begin
			case (index_reg)
				sound_pkg::REG_VOICE: begin
					vol_voice_l <= pack_l;
					vol_voice_r <= pack_r;
				end
				sound_pkg::REG_MASTER: begin
					vol_master_l <= pack_l;
					vol_master_r <= pack_r;
				end
				sound_pkg::REG_SYNTH: begin
					vol_synth_l <= pack_l;
					vol_synth_r <= pack_r;
				end
				default: ;
			endcase
			if (!enhanced) begin // individual regs only exist in normal mode
				case (index_reg)
					sound_pkg::REG_MASTER_L: vol_master_l <= writedata[7:3];
					sound_pkg::REG_MASTER_R: vol_master_r <= writedata[7:3];
					sound_pkg::REG_VOICE_L:  vol_voice_l  <= writedata[7:3];
					sound_pkg::REG_VOICE_R:  vol_voice_r  <= writedata[7:3];
					sound_pkg::REG_SYNTH_L:  vol_synth_l  <= writedata[7:3];
					sound_pkg::REG_SYNTH_R:  vol_synth_r  <= writedata[7:3];
					default: ;
				endcase
			end
		end
	end

	// mode and irq select share one index
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enhanced  <= 1'b0;
			irq_7_en  <= 1'b0;
			irq_10_en <= 1'b0;
		end else if (data_wr && index_reg == sound_pkg::REG_IRQ_SEL) begin
			if (writedata == 8'hAD) begin
				enhanced <= 1'b1;
			end else if (writedata == 8'hAE) begin
				enhanced <= 1'b0;
			end else begin
				irq_7_en  <= (writedata[3:2] == 2'b01);
				irq_10_en <= (writedata[3:2] == 2'b10);
			end
		end
	end

	assign irq_5_en = !irq_7_en && !irq_10_en; // default line
	assign irq_5    = irq && irq_5_en;
	assign irq_7    = irq && irq_7_en;
	assign irq_10   = irq && irq_10_en;

	assign vol_mask = enhanced ? 8'hEE : 8'hFF;

	always_comb begin
		reg_val = 8'h00;
		case (index_reg)
			sound_pkg::REG_VOICE:   reg_val = {vol_voice_l[4:1], vol_voice_r[4:1]} & vol_mask;
			sound_pkg::REG_MASTER:  reg_val = {vol_master_l[4:1], vol_master_r[4:1]} & vol_mask;
			sound_pkg::REG_SYNTH:   reg_val = {vol_synth_l[4:1], vol_synth_r[4:1]} & vol_mask;
			sound_pkg::REG_IRQ_SEL: reg_val = {4'h0, irq_10_en, irq_7_en, irq_5_en, 1'b0};
			default: ;
		endcase
		if (!enhanced) begin
			case (index_reg)
				sound_pkg::REG_MASTER_L: reg_val = {vol_master_l, 3'd0};
				sound_pkg::REG_MASTER_R: reg_val = {vol_master_r, 3'd0};
				sound_pkg::REG_VOICE_L:  reg_val = {vol_voice_l, 3'd0};
				sound_pkg::REG_VOICE_R:  reg_val = {vol_voice_r, 3'd0};
				sound_pkg::REG_SYNTH_L:  reg_val = {vol_synth_l, 3'd0};
				sound_pkg::REG_SYNTH_R:  reg_val = {vol_synth_r, 3'd0};
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (read)
			readdata <= (address == 4'd5) ? reg_val : 8'h00; // only the data port reads back
	end

endmodule

//--- hw/volume_stage.sv
// volume_stage: first pipeline stage, voice and synth volume scaling
module volume_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample_strobe,
	input  sound_pkg::sample_t  dsp_l,
	input  sound_pkg::sample_t  dsp_r,
	input  sound_pkg::sample_t  fm_l,
	input  sound_pkg::sample_t  fm_r,
	input  sound_pkg::vol_t     vol_voice_l,
	input  sound_pkg::vol_t     vol_voice_r,
	input  sound_pkg::vol_t     vol_synth_l,
	input  sound_pkg::vol_t     vol_synth_r,
	output logic                mid_strobe,
	output sound_pkg::sample_t  scaled_dsp_l,
	output sound_pkg::sample_t  scaled_dsp_r,
	output sound_pkg::sample_t  scaled_fm_l,
	output sound_pkg::sample_t  scaled_fm_r
);

	// strobe follows the data by one edge
	always_ff @(posedge clk) begin
		if (!rst_n)
			mid_strobe <= 1'b0;
		else
			mid_strobe <= sample_strobe;
	end

	// digital channel by voice volume
	always_ff @(posedge clk) begin
		if (sample_strobe) begin
			scaled_dsp_l <= sound_pkg::volume(dsp_l, vol_voice_l);
			scaled_dsp_r <= sound_pkg::volume(dsp_r, vol_voice_r);
		end
	end

	// synth by synth volume
	always_ff @(posedge clk) begin
		if (sample_strobe) begin
			scaled_fm_l <= sound_pkg::volume(fm_l, vol_synth_l);
			scaled_fm_r <= sound_pkg::volume(fm_r, vol_synth_r);
		end
	end

endmodule

//--- hw/output_sum.sv
// output_sum: second pipeline stage, halved sum and master volume
module output_sum (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mid_strobe,
	input  sound_pkg::sample_t  scaled_dsp_l,
	input  sound_pkg::sample_t  scaled_dsp_r,
	input  sound_pkg::sample_t  scaled_fm_l,
	input  sound_pkg::sample_t  scaled_fm_r,
	input  sound_pkg::vol_t     vol_master_l,
	input  sound_pkg::vol_t     vol_master_r,
	output logic                out_strobe,
	output sound_pkg::sample_t  out_l,
	output sound_pkg::sample_t  out_r
);

	sound_pkg::sample_t sum_l;
	sound_pkg::sample_t sum_r;

	// each input halved first so the sum stays in range
	assign sum_l = (scaled_dsp_l >>> 1) + (scaled_fm_l >>> 1);
	assign sum_r = (scaled_dsp_r >>> 1) + (scaled_fm_r >>> 1);

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_strobe <= 1'b0;
		else
			out_strobe <= mid_strobe;
	end

	always_ff @(posedge clk) begin
		if (mid_strobe) begin
			out_l <= sound_pkg::volume(sum_l, vol_master_l); // master left
			out_r <= sound_pkg::volume(sum_r, vol_master_r);
		end
	end

endmodule

//--- hw/sound_mix_top.sv
// sound_mix_top: mixer register block and the two-stage sample pipeline
module sound_mix_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [3:0]          address,
	input  logic                read,
	input  logic                write,
	input  logic [7:0]          writedata,
	output logic [7:0]          readdata,
	input  logic                irq,
	output logic                irq_5,
	output logic                irq_7,
	output logic                irq_10,
	input  logic                sample_strobe,
	input  sound_pkg::sample_t  dsp_l,
	input  sound_pkg::sample_t  dsp_r,
	input  sound_pkg::sample_t  fm_l,
	input  sound_pkg::sample_t  fm_r,
	output logic                out_strobe,
	output sound_pkg::sample_t  out_l,
	output sound_pkg::sample_t  out_r
);

	sound_pkg::vol_t    vol_master_l;
	sound_pkg::vol_t    vol_master_r;
	sound_pkg::vol_t    vol_voice_l;
	sound_pkg::vol_t    vol_voice_r;
	sound_pkg::vol_t    vol_synth_l;
	sound_pkg::vol_t    vol_synth_r;
	logic               mid_strobe;
	sound_pkg::sample_t scaled_dsp_l;
	sound_pkg::sample_t scaled_dsp_r;
	sound_pkg::sample_t scaled_fm_l;
	sound_pkg::sample_t scaled_fm_r;

	mixer_regs u_regs (
		.clk, .rst_n,
		.address, .read, .write, .writedata, .irq,
		.readdata,
		.irq_5, .irq_7, .irq_10,
		.vol_master_l, .vol_master_r,
		.vol_voice_l, .vol_voice_r,
		.vol_synth_l, .vol_synth_r
	);

	// stage 1, channel volumes
	volume_stage u_stage1 (
		.clk, .rst_n,
		.sample_strobe,
		.dsp_l, .dsp_r, .fm_l, .fm_r,
		.vol_voice_l, .vol_voice_r, .vol_synth_l, .vol_synth_r,
		.mid_strobe,
		.scaled_dsp_l, .scaled_dsp_r, .scaled_fm_l, .scaled_fm_r
	);

	// stage 2, sum and master
	output_sum u_stage2 (
		.clk, .rst_n,
		.mid_strobe,
		.scaled_dsp_l, .scaled_dsp_r, .scaled_fm_l, .scaled_fm_r,
		.vol_master_l, .vol_master_r,
		.out_strobe, .out_l, .out_r
	);

endmodule

//--- bench/sound_model.svh
// reference model: nibble expansion, register readback, volume scaling, two-stage mix
`ifndef SOUND_MODEL_SVH
`define SOUND_MODEL_SVH

// position of a packed register's left volume in the shadow array, -1 if not packed
function automatic int packed_base(logic [7:0] idx);
	if (idx == sound_pkg::REG_MASTER)
		return 0;
	if (idx == sound_pkg::REG_VOICE)
		return 2;
	if (idx == sound_pkg::REG_SYNTH)
		return 4;
	return -1;
endfunction

function automatic logic [4:0] expand_nibble(logic [3:0] nib, logic enh);
	if (enh)
		return {nib[3:1], nib[3:2]}; // three bits then two
	return {nib, nib[3]};
endfunction

// v holds the volumes in single-register order, master_l first
function automatic logic [7:0] expected_read(logic [7:0] idx, logic [4:0] v[6], logic enh,
		int line);
	int base;
	base = packed_base(idx);
	if (base >= 0)
		return {v[base][4:1], v[base + 1][4:1]} & (enh ? 8'hEE : 8'hFF);
	if (idx >= sound_pkg::REG_MASTER_L && idx <= sound_pkg::REG_SYNTH_R)
		return enh ? 8'h00 : {v[int'(idx - sound_pkg::REG_MASTER_L)], 3'b000};
	if (idx == sound_pkg::REG_IRQ_SEL)
		return {4'h0, line == 10, line == 7, line == 5, 1'b0};
	return 8'h00;
endfunction

// rounds toward minus infinity like an arithmetic shift
function automatic int floor_div(int x, int d);
	if (x >= 0)
		return x / d;
	return -((-x + d - 1) / d);
endfunction

function automatic int scale_ref(int smp, logic [4:0] vol);
	if (vol == 5'd0)
		return 0;
	return floor_div(smp, 1 << (15 - int'(vol[4:1])));
endfunction

function automatic int mix_ref(int dsp, int fm, logic [4:0] v_dsp, logic [4:0] v_fm,
		logic [4:0] v_master);
	int a;
	int b;
	a = scale_ref(dsp, v_dsp);
	b = scale_ref(fm, v_fm);
	return scale_ref(floor_div(a, 2) + floor_div(b, 2), v_master);
endfunction

`endif

//--- bench/sound_mix_tb.sv
// testbench for sound_mix_top: register access, irq routing and the sample pipeline
module sound_mix_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000; // 200 isolated samples at ~40 cycles each, plus margin

	logic               clk;
	logic               rst_n = 1'b0;
	logic [3:0]         address = 4'd0;
	logic               read = 1'b0;
	logic               write = 1'b0;
	logic [7:0]         writedata = 8'h00;
	logic [7:0]         readdata;
	logic               irq = 1'b0;
	logic               irq_5;
	logic               irq_7;
	logic               irq_10;
	logic               sample_strobe = 1'b0;
	sound_pkg::sample_t dsp_l = '0;
	sound_pkg::sample_t dsp_r = '0;
	sound_pkg::sample_t fm_l = '0;
	sound_pkg::sample_t fm_r = '0;
	logic               out_strobe;
	sound_pkg::sample_t out_l;
	sound_pkg::sample_t out_r;

	logic [4:0] vol_m [6] = '{default: 5'd31}; // shadow volumes
	logic       enh_m = 1'b0;
	int         irq_line_m = 5;
	sound_pkg::reg_index_t packed_regs [3] = '{sound_pkg::REG_MASTER, sound_pkg::REG_VOICE,
		sound_pkg::REG_SYNTH};
	logic [7:0] irq_sel_data [3] = '{8'h04, 8'h08, 8'h00};

	int cycle = 0;
	int errors = 0;
	int cmp_errors = 0;
	int checks = 0;
	int cmp_checks = 0;
	int out_count = 0;
	int test_num = 0;
	int errors_before = 0;
	int exp_l_q [$];
	int exp_r_q [$];
	int exp_cyc_q [$];
	int exp_l;
	int exp_r;
	int exp_cyc;

	`include "sound_model.svh"

	sound_mix_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// expected pairs in, DUT pairs out
	always @(posedge clk) begin
		if (rst_n && out_strobe) begin
			out_count++;
			assert (exp_l_q.size() != 0) else begin
				$display("out_strobe came with no sample in flight at time %0t", $time);
				cmp_errors++;
			end
			if (exp_l_q.size() != 0) begin
				exp_l = exp_l_q.pop_front();
				exp_r = exp_r_q.pop_front();
				exp_cyc = exp_cyc_q.pop_front();
				cmp_checks++;
				assert (int'(out_l) == exp_l && int'(out_r) == exp_r) else begin
					$display("[ERROR] %0t: out %0d/%0d, expected %0d/%0d", $time, out_l, out_r,
						exp_l, exp_r);
					cmp_errors++;
				end
				assert (cycle - exp_cyc == 2) else begin
					$display("[ERROR] %0t: output %0d cycles after its strobe, expected 2",
						$time, cycle - exp_cyc);
					cmp_errors++;
				end
			end
		end
		if (rst_n && sample_strobe) begin
			exp_l_q.push_back(mix_ref(int'(dsp_l), int'(fm_l), vol_m[2], vol_m[4], vol_m[0]));
			exp_r_q.push_back(mix_ref(int'(dsp_r), int'(fm_r), vol_m[3], vol_m[5], vol_m[1]));
			exp_cyc_q.push_back(cycle);
		end
	end

	task automatic host_write(input logic [3:0] addr, input logic [7:0] data);
		@(negedge clk);
		address = addr;
		writedata = data;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic host_read(input logic [3:0] addr, output logic [7:0] data);
		@(negedge clk);
		address = addr;
		read = 1'b1;
		@(negedge clk);
		read = 1'b0;
		data = readdata; // registered on the edge between
	endtask

	function automatic void model_write(logic [7:0] idx, logic [7:0] data);
		int base;
		base = packed_base(idx);
		if (base >= 0) begin
			vol_m[base] = expand_nibble(data[7:4], enh_m);
			vol_m[base + 1] = expand_nibble(data[3:0], enh_m);
		end else if (idx >= sound_pkg::REG_MASTER_L && idx <= sound_pkg::REG_SYNTH_R) begin
			if (!enh_m)
				vol_m[int'(idx - sound_pkg::REG_MASTER_L)] = data[7:3];
		end else if (idx == sound_pkg::REG_RESET) begin
			vol_m = '{default: 5'd31};
		end else if (idx == sound_pkg::REG_IRQ_SEL) begin
			if (data == 8'hAD)
				enh_m = 1'b1;
			else if (data == 8'hAE)
				enh_m = 1'b0;
			else
				irq_line_m = (data[3:2] == 2'b01) ? 7 : (data[3:2] == 2'b10) ? 10 : 5;
		end
	endfunction

	task automatic write_reg(input logic [7:0] idx, input logic [7:0] data);
		host_write(4'd4, idx);
		host_write(4'd5, data);
		model_write(idx, data);
	endtask

	task automatic check_read(input logic [7:0] idx);
		logic [7:0] got;
		logic [7:0] exp;
		exp = expected_read(idx, vol_m, enh_m, irq_line_m);
		host_write(4'd4, idx);
		host_read(4'd5, got);
		checks++;
		assert (got == exp) else begin
			$display("[ERROR] %0t: reg %02h read %02h, expected %02h", $time, idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_irq();
		@(negedge clk);
		irq = 1'b1;
		@(posedge clk);
		checks++;
		assert ({irq_10, irq_7, irq_5} == {irq_line_m == 10, irq_line_m == 7, irq_line_m == 5})
			else begin
			$display("[ERROR] %0t: irq lines %b, expected irq_%0d only", $time,
				{irq_10, irq_7, irq_5}, irq_line_m);
			errors++;
		end
		@(negedge clk);
		irq = 1'b0;
	endtask

	task automatic random_writes(input int n);
		logic [7:0] idx;
		int         k;
		repeat (n) begin
			idx = packed_regs[int'($urandom % 3)];
			write_reg(idx, 8'($urandom));
			check_read(idx);
			k = int'($urandom % 6);
			write_reg(sound_pkg::REG_MASTER_L + 8'(k), 8'($urandom));
			check_read(sound_pkg::REG_MASTER_L + 8'(k));
			check_read(packed_regs[k / 2]); // other side must be unchanged
		end
	endtask

	function automatic logic [7:0] random_volume();
		logic [4:0] v;
		case ($urandom % 8)
			0: v = 5'd0;
			1: v = 5'd31;
			default: v = 5'($urandom);
		endcase
		return {v, 3'($urandom)};
	endfunction

	task automatic set_volumes();
		for (int k = 0; k < 6; k++)
			write_reg(sound_pkg::REG_MASTER_L + 8'(k), random_volume());
	endtask

	task automatic send_sample();
		@(negedge clk);
		sample_strobe = 1'b1;
		dsp_l = 16'($urandom);
		dsp_r = 16'($urandom);
		fm_l = 16'($urandom);
		fm_r = 16'($urandom);
	endtask

	task automatic end_samples();
		@(negedge clk);
		sample_strobe = 1'b0;
		while (exp_l_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // room for a stray extra output
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors + cmp_errors - errors_before);
		errors_before = errors + cmp_errors;
	endtask

	initial begin
		int seed_disc;
		int out_before;
		seed_disc = $urandom(17645);
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		foreach (packed_regs[i])
			check_read(packed_regs[i]);
		check_read(sound_pkg::REG_IRQ_SEL);
		check_irq();
		end_test("reset defaults");

		random_writes(20);
		end_test("normal mode writes");

		foreach (irq_sel_data[i]) begin
			write_reg(sound_pkg::REG_IRQ_SEL, irq_sel_data[i]);
			check_read(sound_pkg::REG_IRQ_SEL);
			check_irq();
		end
		write_reg(sound_pkg::REG_IRQ_SEL, 8'hAD);
		random_writes(10);
		write_reg(sound_pkg::REG_IRQ_SEL, 8'hAE);
		foreach (packed_regs[i])
			check_read(packed_regs[i]);
		write_reg(sound_pkg::REG_RESET, 8'h00);
		foreach (packed_regs[i])
			check_read(packed_regs[i]);
		end_test("irq select and enhanced mode");

		repeat (200) begin
			set_volumes();
			send_sample();
			end_samples();
		end
		end_test("isolated samples");

		set_volumes();
		out_before = out_count;
		repeat (100)
			send_sample();
		end_samples();
		checks++;
		assert (out_count - out_before == 100) else begin
			$display("100 back-to-back samples gave %0d outputs", out_count - out_before);
			errors++;
		end
		end_test("back-to-back samples");

		$display("%0d tests, %0d checks, %0d errors", test_num, checks + cmp_checks,
			errors + cmp_errors);
		if (errors + cmp_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sound_mix.f
+incdir+bench
hw/sound_pkg.sv
hw/mixer_regs.sv
hw/volume_stage.sv
hw/output_sum.sv
hw/sound_mix_top.sv
bench/sound_mix_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the mixer testbench with Verilator, run it, judge the run from its log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module sound_mix_tb \
	-f sound_mix.f \
	-o sound_mix_sim

./obj_dir/sound_mix_sim > sim.log
cat sim.log

grep -qx "TEST OK" sim.log
